/* vlog.f */
+incdir+dv
design/fpu_types_pkg.sv
design/fpu_regs_pkg.sv
design/fcvt_ifs.sv
design/fpu_stage.sv
design/fcvt_decode.sv
design/float_convert.sv
design/fcvt_result.sv
design/fcvt_top.sv
dv/fcvt_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module fcvt_tb -f vlog.f -o fcvt_sim &&
	obj_dir/fcvt_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }

/* dv/fcvt_vectors.svh */
`ifndef FCVT_VECTORS_SVH
`define FCVT_VECTORS_SVH

// each row holds operand, op, rm, expected value, expected flags {nv, of, nx} and test name

localparam int NAME_W = 8 * 16;
localparam int NUM_VECTORS = 22;

// flag patterns as they read back from STATUS[6:4]
localparam logic [2:0] F_NONE = 3'b000;
localparam logic [2:0] F_NX = 3'b001;
localparam logic [2:0] F_NV = 3'b100;
localparam logic [2:0] F_OFNX = 3'b011;

typedef struct packed {
	logic [31:0] operand;
	logic [1:0] op;
	logic [2:0] rm;
	logic [31:0] value;
	logic [2:0] flags;
	logic [NAME_W-1:0] name;
} fcvt_vector_t;

localparam fcvt_vector_t VECTORS [NUM_VECTORS] = '{
	// half to signed word truncates and saturates
	'{32'h0000_4500, FUNCT_W_H, RM_RTZ, 32'h0000_0005, F_NONE, "w.h 5.0"},
	'{32'h0000_C500, FUNCT_W_H, RM_RTZ, 32'hFFFF_FFFB, F_NONE, "w.h -5.0"},
	'{32'h0000_3800, FUNCT_W_H, RM_RTZ, 32'h0000_0000, F_NX, "w.h 0.5"},
	'{32'h0000_3E00, FUNCT_W_H, RM_RTZ, 32'h0000_0001, F_NX, "w.h 1.5"},
	'{32'h0000_7C00, FUNCT_W_H, RM_RTZ, 32'h7FFF_FFFF, F_NV, "w.h +inf"},
	'{32'h0000_FC00, FUNCT_W_H, RM_RTZ, 32'h8000_0000, F_NV, "w.h -inf"},
	// a nan with the sign bit set still saturates high
	'{32'h0000_FD01, FUNCT_W_H, RM_RTZ, 32'h7FFF_FFFF, F_NV, "w.h -nan"},
	// half to unsigned word
	'{32'h0000_4A00, FUNCT_WU_H, RM_RTZ, 32'h0000_000C, F_NONE, "wu.h 12.0"},
	'{32'h0000_C500, FUNCT_WU_H, RM_RTZ, 32'h0000_0000, F_NV, "wu.h -5.0"},
	'{32'h0000_7C00, FUNCT_WU_H, RM_RTZ, 32'hFFFF_FFFF, F_NV, "wu.h +inf"},
	// exact word to half
	'{32'h0000_0000, FUNCT_H_W, RM_RNE, 32'h0000_0000, F_NONE, "h.w 0"},
	'{32'h0000_0001, FUNCT_H_W, RM_RNE, 32'h0000_3C00, F_NONE, "h.w 1"},
	'{32'hFFFF_FFFE, FUNCT_H_W, RM_RNE, 32'h0000_C000, F_NONE, "h.w -2"},
	'{32'h0000_0400, FUNCT_H_W, RM_RNE, 32'h0000_6400, F_NONE, "h.w 1024"},
	'{32'h8000_0000, FUNCT_H_WU, RM_RNE, 32'h0000_7C00, F_OFNX, "h.wu 2^31"},
	// 2049 sits halfway between 2048 and 2050
	'{32'h0000_0801, FUNCT_H_W, RM_RNE, 32'h0000_6800, F_NX, "h.w 2049 rne"},
	'{32'h0000_0801, FUNCT_H_W, RM_RMM, 32'h0000_6801, F_NX, "h.w 2049 rmm"},
	'{32'h0000_0801, FUNCT_H_W, RM_RUP, 32'h0000_6801, F_NX, "h.w 2049 rup"},
	'{32'h0000_0801, FUNCT_H_W, RM_RTZ, 32'h0000_6800, F_NX, "h.w 2049 rtz"},
	'{32'hFFFF_F7FF, FUNCT_H_W, RM_RDN, 32'h0000_E801, F_NX, "h.w -2049 rdn"},
	// beyond 65504
	'{32'h0001_1170, FUNCT_H_W, RM_RNE, 32'h0000_7C00, F_OFNX, "h.w 70000 rne"},
	'{32'h0001_1170, FUNCT_H_W, RM_RTZ, 32'h0000_7BFF, F_OFNX, "h.w 70000 rtz"}
};

`endif

/* dv/fcvt_tb.sv */
module fcvt_tb
	import fpu_types_pkg::*;
	import fpu_regs_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	`include "fcvt_vectors.svh"

	// done clear, write to RESULT, bad read address and response count
	localparam int NUM_PROTOCOL = 4;
	localparam int CYCLE_LIMIT = 16 + 60 * (NUM_VECTORS + NUM_PROTOCOL);

	logic clk;
	logic rst;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [AXI_DATA_W-1:0] wdata;
	logic [AXI_STRB_W-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [RESP_W-1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [AXI_DATA_W-1:0] rdata;
	logic [RESP_W-1:0] rresp;
	logic rvalid;
	logic rready;

	logic [15:0] lfsr_state;
	logic stalls_on;
	int test_errors;
	int test_num;
	int tests_passed;
	int tests_failed;
	int writes_issued;
	int reads_issued;
	logic b_pending = 1'b0;
	logic r_pending = 1'b0;
	int b_seen = 0;
	int r_seen = 0;
	int cycle_count = 0;

	fcvt_top fcvt_top_i (
		.clk(clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// a response held over stall cycles counts once
	always @(posedge clk) begin
		if (bvalid && !b_pending) b_seen++;
		if (rvalid && !r_pending) r_seen++;
		b_pending = bvalid && !bready;
		r_pending = rvalid && !rready;
	end

	// hard stop so a hung handshake cannot stall the run
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// galois lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one step per bit drawn
	task automatic draw_stall(output logic stall);
		lfsr_state = lfsr_next(lfsr_state);
		stall = lfsr_state[0] & stalls_on;
	endtask

	function automatic logic [31:0] ctrl_word(input logic [1:0] op, input logic [2:0] rm);
		logic [31:0] w;
		w = '0;
		w[CTRL_OP_MSB:CTRL_OP_LSB] = op;
		w[CTRL_RM_MSB:CTRL_RM_LSB] = rm;
		return w;
	endfunction

	task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("** Error at %0t: %s expected %h, got %h", $time, sig, exp, act);
			test_errors++;
		end
	endtask

	// called and returns at a falling edge
	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
			output logic [RESP_W-1:0] resp);
		logic stall;
		awaddr = addr[AXI_ADDR_W-1:0];
		wdata = data;
		wstrb = '1;
		awvalid = 1'b1;
		wvalid = 1'b1;
		writes_issued++;
		@(posedge clk);
		while (!awready) @(posedge clk);
		// data is taken in the same cycle as the address
		check_value("wready", 32'd1, 32'(wready));
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		// maybe hold off the response one extra cycle
		draw_stall(stall);
		if (stall) @(negedge clk);
		bready = 1'b1;
		@(posedge clk);
		while (!bvalid) @(posedge clk);
		resp = bresp;
		@(negedge clk);
		bready = 1'b0;
		assert (!bvalid) else begin
			$display("write response at %0t was presented a second time", $time);
			test_errors++;
		end
	endtask

	task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
			output logic [RESP_W-1:0] resp);
		logic stall;
		// upper address bits fall away on the narrow bus
		araddr = addr[AXI_ADDR_W-1:0];
		arvalid = 1'b1;
		reads_issued++;
		@(posedge clk);
		while (!arready) @(posedge clk);
		@(negedge clk);
		arvalid = 1'b0;
		draw_stall(stall);
		if (stall) @(negedge clk);
		rready = 1'b1;
		@(posedge clk);
		while (!rvalid) @(posedge clk);
		data = rdata;
		resp = rresp;
		@(negedge clk);
		rready = 1'b0;
		assert (!rvalid) else begin
			$display("read response at %0t was presented a second time", $time);
			test_errors++;
		end
	endtask

	// poll STATUS until done
	task automatic wait_done(output logic [31:0] status);
		logic [RESP_W-1:0] resp;
		status = '0;
		while (!status[STATUS_DONE_BIT]) begin
			axi_read(32'(REG_STATUS), status, resp);
			check_value("rresp status", 32'(RESP_OKAY), 32'(resp));
		end
	endtask

	task automatic run_vector(input fcvt_vector_t v);
		logic [RESP_W-1:0] resp;
		logic [31:0] status;
		logic [31:0] data;
		axi_write(32'(REG_OPERAND), v.operand, resp);
		check_value("bresp operand", 32'(RESP_OKAY), 32'(resp));
		axi_write(32'(REG_CTRL), ctrl_word(v.op, v.rm), resp);
		check_value("bresp ctrl", 32'(RESP_OKAY), 32'(resp));
		wait_done(status);
		check_value("status flags", 32'(v.flags), 32'(status[STATUS_FLAG_MSB:STATUS_FLAG_LSB]));
		axi_read(32'(REG_RESULT), data, resp);
		check_value("rresp result", 32'(RESP_OKAY), 32'(resp));
		check_value("rdata result", v.value, data);
	endtask

	task automatic end_test(input logic [NAME_W-1:0] name);
		test_num++;
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %0d %s: pass", test_num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: fail, %0d errors", test_num, name, test_errors);
		end
		test_errors = 0;
	endtask

	initial begin
		logic [RESP_W-1:0] resp;
		logic [31:0] data;
		clk = 1'b0;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		lfsr_state = 16'd42;
		stalls_on = 1'b1;
		test_errors = 0;
		test_num = 0;
		tests_passed = 0;
		tests_failed = 0;
		writes_issued = 0;
		reads_issued = 0;
		repeat (16) @(negedge clk);
		rst = 1'b0;

		for (int i = 0; i < NUM_VECTORS; i++) begin
			run_vector(VECTORS[i]);
			end_test(VECTORS[i].name);
		end

		// done must be clear when STATUS is read straight after CTRL
		stalls_on = 1'b0;
		axi_write(32'(REG_OPERAND), 32'd3, resp);
		axi_write(32'(REG_CTRL), ctrl_word(FUNCT_H_W, RM_RNE), resp);
		axi_read(32'(REG_STATUS), data, resp);
		check_value("status done", 32'd0, 32'(data[STATUS_DONE_BIT]));
		wait_done(data);
		axi_read(32'(REG_RESULT), data, resp);
		check_value("rdata result", 32'h0000_4200, data);
		stalls_on = 1'b1;
		end_test("done clear");

		// read-only RESULT keeps 3.0 as half through the write
		axi_write(32'(REG_RESULT), 32'hDEAD_BEEF, resp);
		check_value("bresp", 32'(RESP_SLVERR), 32'(resp));
		axi_read(32'(REG_RESULT), data, resp);
		check_value("rdata result", 32'h0000_4200, data);
		end_test("write result");

		// 0x10 wraps onto the write-only OPERAND slot
		axi_read(32'h0000_0010, data, resp);
		check_value("rresp", 32'(RESP_SLVERR), 32'(resp));
		check_value("rdata", 32'd0, data);
		end_test("read 0x10");

		// one response per transfer, none lost and none repeated
		check_value("b responses", 32'(writes_issued), 32'(b_seen));
		check_value("r responses", 32'(reads_issued), 32'(r_seen));
		end_test("response count");

		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* design/fcvt_top.sv */
module fcvt_top
	import fpu_types_pkg::*;
	import fpu_regs_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic [AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [AXI_DATA_W-1:0] wdata,
	input logic [AXI_STRB_W-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [RESP_W-1:0] bresp,
	output logic bvalid,
	input logic bready,

	input logic [AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [AXI_DATA_W-1:0] rdata,
	output logic [RESP_W-1:0] rresp,
	output logic rvalid,
	input logic rready
);

	logic launched;

	// decode -> cmd_stage -> float_convert -> res_stage -> result
	fcvt_cmd_if dec_cmd ();
	fcvt_cmd_if stg_cmd ();
	fcvt_res_if cvt_res ();
	fcvt_res_if stg_res ();

	fcvt_decode decode_i (
		.clk(clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.cmd(dec_cmd),
		.launched(launched)
	);

	fpu_stage #(
		.payload_t(fcvt_cmd_t)
	) cmd_stage (
		.clk(clk),
		.rst(rst),
		.in_valid(dec_cmd.valid),
		.in_data(dec_cmd.cmd),
		.out_valid(stg_cmd.valid),
		.out_data(stg_cmd.cmd)
	);

	float_convert execute_i (
		.cmd(stg_cmd),
		.res(cvt_res)
	);

	fpu_stage #(
		.payload_t(fcvt_res_t)
	) res_stage (
		.clk(clk),
		.rst(rst),
		.in_valid(cvt_res.valid),
		.in_data(cvt_res.res),
		.out_valid(stg_res.valid),
		.out_data(stg_res.res)
	);

	fcvt_result result_i (
		.clk(clk),
		.rst(rst),
		.res(stg_res),
		.launched(launched),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

endmodule

/* design/fcvt_result.sv */
module fcvt_result
	import fpu_types_pkg::*;
	import fpu_regs_pkg::*;
(
	input logic clk,
	input logic rst,

	// finished conversions
	fcvt_res_if.dst res,
	input logic launched,

	// axi4-lite read address and data
	input logic [AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [AXI_DATA_W-1:0] rdata,
	output logic [RESP_W-1:0] rresp,
	output logic rvalid,
	input logic rready
);

	logic [WORD_W-1:0] result_q;
	fpu_flags_t flags_q;
	logic done;
	logic ar_fire;
	logic [AXI_DATA_W-1:0] status_word;

	// latest result wins, a new launch hides the old done
	always_ff @(posedge clk) begin
		if (rst) begin
			result_q <= '0;
			flags_q <= '0;
			done <= 1'b0;
		end else begin
			if (res.valid) begin
				result_q <= res.res.value;
				flags_q <= res.res.flags;
			end
			if (launched) begin
				done <= 1'b0;
			end else if (res.valid) begin
				done <= 1'b1;
			end
		end
	end

	always_comb begin
		status_word = '0;
		status_word[STATUS_DONE_BIT] = done;
		status_word[STATUS_FLAG_MSB:STATUS_FLAG_LSB] = flags_q;
	end

	assign ar_fire = arvalid & arready;

	// arready drops while a response waits for rready
	always_ff @(posedge clk) begin
		if (rst) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else if (ar_fire) begin
			arready <= 1'b0;
			rvalid <= 1'b1;
		end else if (rvalid && rready) begin
			arready <= 1'b1;
			rvalid <= 1'b0;
		end else if (!rvalid) begin
			arready <= 1'b1;
		end
	end

	// read data captured at the address handshake
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			case (araddr)
				REG_RESULT: begin
					rdata <= result_q;
					rresp <= RESP_OKAY;
				end
				REG_STATUS: begin
					rdata <= status_word;
					rresp <= RESP_OKAY;
				end
				default: begin
					// write-only and unmapped
					rdata <= '0;
					rresp <= RESP_SLVERR;
				end
			endcase
		end
	end

endmodule

/* design/float_convert.sv */
module float_convert
	import fpu_types_pkg::*;
(
	fcvt_cmd_if.dst cmd,
	fcvt_res_if.src res
);

	fcvt_cmd_t c;
	fcvt_res_t r;

	// half source side
	logic [HALF_FLOAT_W-1:0] h_raw;
	logic [HALF_FLOAT_W-1:0] h;
	logic h_is_nan;
	logic h_sign;
	logic [HALF_EXPONENT_W-1:0] h_exp;
	logic [HALF_FRACTION_W-1:0] h_frac;
	logic h_is_special;
	logic h_to_signed;
	logic [HALF_EXPONENT_W-1:0] h_shift;
	logic [HALF_FRACTION_W+HALF_BIAS:0] h_fixed;
	logic [WORD_W-1:0] h_mag;
	logic h_lost;

	// word source side
	logic w_neg;
	logic [WORD_W-1:0] w_mag;
	logic [4:0] w_msb;
	logic [4:0] w_lz;
	logic [WORD_W-1:0] w_norm;
	logic [HALF_FRACTION_W:0] w_sig;
	logic w_guard;
	logic w_sticky;
	logic w_inc;
	logic [HALF_FRACTION_W+1:0] w_sig_r;
	logic [6:0] w_exp_r;
	logic w_ovf;
	logic w_to_max;
	logic [HALF_FLOAT_W-1:0] w_half;

	assign c = cmd.cmd;

	// any nan collapses to the positive canonical one, sign is ignored
	assign h_raw = c.operand[HALF_FLOAT_W-1:0];
	assign h_is_nan = (h_raw[HALF_FLOAT_W-SIGN_W-1 -: HALF_EXPONENT_W] == '1) &&
		(h_raw[HALF_FRACTION_W-1:0] != '0);
	assign h = h_is_nan ? HALF_NAN : h_raw;

	assign h_sign = h[HALF_FLOAT_W-1];
	assign h_exp = h[HALF_FLOAT_W-SIGN_W-1 -: HALF_EXPONENT_W];
	assign h_frac = h[HALF_FRACTION_W-1:0];
	assign h_is_special = (h_exp == '1);
	assign h_to_signed = (c.op == FUNCT_W_H);

	// place 1.frac as fixed point, ten fraction bits below the integer
	assign h_shift = h_exp - HALF_EXPONENT_W'(HALF_BIAS);
	assign h_fixed = {{HALF_BIAS{1'b0}}, 1'b1, h_frac} << h_shift;
	assign h_mag = {{(WORD_W-HALF_FLOAT_W){1'b0}},
		h_fixed[HALF_FRACTION_W+HALF_BIAS:HALF_FRACTION_W]};
	assign h_lost = |h_fixed[HALF_FRACTION_W-1:0];

	// only fcvt.h.w reads the word as two's complement
	assign w_neg = (c.op == FUNCT_H_W) & c.operand[WORD_W-1];
	assign w_mag = w_neg ? -c.operand : c.operand;

	// leading one search, highest set bit wins
	always_comb begin
		w_msb = '0;
		for (int i = 0; i < WORD_W; i++) begin
			if (w_mag[i]) begin
				w_msb = 5'(i);
			end
		end
	end

	// normalise so the leading one sits at the word msb
	assign w_lz = 5'(WORD_W - 1) - w_msb;
	assign w_norm = w_mag << w_lz;
	assign w_sig = w_norm[WORD_W-1 -: HALF_FRACTION_W+1];
	assign w_guard = w_norm[WORD_W-HALF_FRACTION_W-2];
	assign w_sticky = |w_norm[WORD_W-HALF_FRACTION_W-3:0];

	// round increment by mode
	always_comb begin
		case (c.rm)
			RM_RNE: w_inc = w_guard & (w_sticky | w_sig[0]);
			RM_RTZ: w_inc = 1'b0;
			RM_RDN: w_inc = w_neg & (w_guard | w_sticky);
			RM_RUP: w_inc = ~w_neg & (w_guard | w_sticky);
			RM_RMM: w_inc = w_guard;
			default: w_inc = 1'b0;
		endcase
	end

	// modes that never round away from zero clamp to the largest finite
	always_comb begin
		case (c.rm)
			RM_RNE, RM_RMM: w_to_max = 1'b0;
			RM_RDN: w_to_max = ~w_neg;
			RM_RUP: w_to_max = w_neg;
			default: w_to_max = 1'b1;
		endcase
	end

	// a carry out of the significand bumps the exponent
	assign w_sig_r = {1'b0, w_sig} + {{(HALF_FRACTION_W+1){1'b0}}, w_inc};
	assign w_exp_r = 7'(w_msb) + 7'(HALF_BIAS) + 7'(w_sig_r[HALF_FRACTION_W+1]);
	assign w_ovf = (w_exp_r > 7'(2**HALF_EXPONENT_W - 2));

	always_comb begin
		if (w_mag == '0) begin
			w_half = HALF_ZERO;
		end else if (w_ovf) begin
			if (w_to_max) begin
				w_half = {w_neg, HALF_MAX_FINITE[HALF_FLOAT_W-2:0]};
			end else begin
				w_half = w_neg ? HALF_INFN : HALF_INF;
			end
		end else begin
			w_half = {w_neg, w_exp_r[HALF_EXPONENT_W-1:0], w_sig_r[HALF_FRACTION_W-1:0]};
		end
	end

	// select by opcode and collect flags
	always_comb begin
		r = '0;
		case (c.op)
			FUNCT_W_H, FUNCT_WU_H: begin
				if (h_is_special) begin
					// inf or nan saturates
					r.flags.nv = 1'b1;
					if (h_sign) begin
						r.value = h_to_signed ? WORD_SMIN : '0;
					end else begin
						r.value = h_to_signed ? WORD_SMAX : WORD_UMAX;
					end
				end else if (h_exp < HALF_EXPONENT_W'(HALF_BIAS)) begin
					// below one, denormals count as zero
					r.flags.nx = (h_exp != '0);
				end else if (h_sign && !h_to_signed) begin
					r.flags.nv = 1'b1;
				end else begin
					r.value = h_sign ? -h_mag : h_mag;
					r.flags.nx = h_lost;
				end
			end
			FUNCT_H_W, FUNCT_H_WU: begin
				r.value = {{(WORD_W-HALF_FLOAT_W){1'b0}}, w_half};
				r.flags.of = w_ovf;
				r.flags.nx = w_ovf | w_guard | w_sticky;
			end
		endcase
	end

	assign res.valid = cmd.valid;
	assign res.res = r;

endmodule

/* design/fcvt_decode.sv */
module fcvt_decode
	import fpu_types_pkg::*;
	import fpu_regs_pkg::*;
(
	input logic clk,
	input logic rst,

	// axi4-lite write address and data
	input logic [AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [AXI_DATA_W-1:0] wdata,
	input logic [AXI_STRB_W-1:0] wstrb,
	input logic wvalid,
	output logic wready,

	// axi4-lite write response
	output logic [RESP_W-1:0] bresp,
	output logic bvalid,
	input logic bready,

	// command towards execute
	fcvt_cmd_if.src cmd,
	// ctrl accepted, clears done on the read side
	output logic launched
);

	logic wr_fire;
	logic hit_operand;
	logic hit_ctrl;
	logic [WORD_W-1:0] operand_q;
	logic cmd_valid_q;
	fcvt_cmd_t cmd_q;

	// address and data taken together, one write in flight at a time
	assign wr_fire = awvalid & wvalid & ~bvalid;
	assign awready = wr_fire;
	assign wready = wr_fire;

	assign hit_operand = (awaddr == REG_OPERAND);
	assign hit_ctrl = (awaddr == REG_CTRL);
	assign launched = wr_fire & hit_ctrl;

	// response follows the handshake by one cycle, held until bready
	always_ff @(posedge clk) begin
		if (rst) begin
			bvalid <= 1'b0;
		end else if (wr_fire) begin
			bvalid <= 1'b1;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	// anything other than the two write registers is an error
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			bresp <= (hit_operand | hit_ctrl) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// operand register, byte lanes under wstrb
	always_ff @(posedge clk) begin
		if (wr_fire && hit_operand) begin
			for (int b = 0; b < AXI_STRB_W; b++) begin
				if (wstrb[b]) begin
					operand_q[8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

	// one command pulse per ctrl write
	always_ff @(posedge clk) begin
		if (rst) begin
			cmd_valid_q <= 1'b0;
		end else begin
			cmd_valid_q <= launched;
		end
	end

	// stored operand plus the fields unpacked from the ctrl word
	always_ff @(posedge clk) begin
		if (launched) begin
			cmd_q.operand <= operand_q;
			cmd_q.op <= fpu_cvt_type_t'(wdata[CTRL_OP_MSB:CTRL_OP_LSB]);
			cmd_q.rm <= fpu_rm_t'(wdata[CTRL_RM_MSB:CTRL_RM_LSB]);
		end
	end

	assign cmd.valid = cmd_valid_q;
	assign cmd.cmd = cmd_q;

endmodule

/* design/fpu_stage.sv */
module fpu_stage #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input payload_t in_data,
	output logic out_valid,
	output payload_t out_data
);

	// valid bit follows its input every cycle, no stall
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// payload only moves with a valid beat
	always_ff @(posedge clk) begin
		if (in_valid) begin
			out_data <= in_data;
		end
	end

endmodule

/* design/fcvt_ifs.sv */
// command path from decode towards execute
interface fcvt_cmd_if
	import fpu_types_pkg::*;
();

	logic valid;
	fcvt_cmd_t cmd;

	modport src (
		output valid,
		output cmd
	);

	modport dst (
		input valid,
		input cmd
	);

endinterface

// result path from execute towards the read side
interface fcvt_res_if
	import fpu_types_pkg::*;
();

	logic valid;
	fcvt_res_t res;

	modport src (
		output valid,
		output res
	);

	modport dst (
		input valid,
		input res
	);

endinterface

/* design/fpu_regs_pkg.sv */
package fpu_regs_pkg;

	// axi4-lite bus geometry
	localparam int AXI_ADDR_W = 4;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;
	localparam int RESP_W = 2;

	// register map, byte addresses
	localparam logic [AXI_ADDR_W-1:0] REG_OPERAND = 4'h0;
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL = 4'h4;
	localparam logic [AXI_ADDR_W-1:0] REG_RESULT = 4'h8;
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 4'hC;

	// bresp / rresp codes
	localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;
	localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

	// ctrl word fields
	localparam int CTRL_OP_LSB = 0;
	localparam int CTRL_OP_MSB = 1;
	localparam int CTRL_RM_LSB = 4;
	localparam int CTRL_RM_MSB = 6;

	// status word fields, flags are nv, of, nx from msb down
	localparam int STATUS_DONE_BIT = 0;
	localparam int STATUS_FLAG_LSB = 4;
	localparam int STATUS_FLAG_MSB = 6;

endpackage

/* design/fpu_types_pkg.sv */
package fpu_types_pkg;

	// half precision layout
	localparam int HALF_FLOAT_W = 16;
	localparam int HALF_EXPONENT_W = 5;
	localparam int HALF_FRACTION_W = 10;
	localparam int SIGN_W = 1;
	localparam int HALF_BIAS = 15;

	// integer side of every conversion
	localparam int WORD_W = 32;

	// canonical half encodings
	localparam logic [HALF_FLOAT_W-1:0] HALF_INF = 16'h7C00;
	localparam logic [HALF_FLOAT_W-1:0] HALF_INFN = 16'hFC00;
	localparam logic [HALF_FLOAT_W-1:0] HALF_NAN = 16'h7E00;
	localparam logic [HALF_FLOAT_W-1:0] HALF_ZERO = 16'h0000;
	// largest finite magnitude, 65504
	localparam logic [HALF_FLOAT_W-1:0] HALF_MAX_FINITE = 16'h7BFF;

	// saturation limits for half to word
	localparam logic [WORD_W-1:0] WORD_SMAX = 32'h7FFF_FFFF;
	localparam logic [WORD_W-1:0] WORD_SMIN = 32'h8000_0000;
	localparam logic [WORD_W-1:0] WORD_UMAX = 32'hFFFF_FFFF;

	// fcvt flavours, destination first as in the isa mnemonic
	typedef enum logic [1:0] {
		FUNCT_W_H = 2'd0,
		FUNCT_WU_H = 2'd1,
		FUNCT_H_W = 2'd2,
		FUNCT_H_WU = 2'd3
	} fpu_cvt_type_t;

	// risc-v rounding modes, 5 to 7 behave as rtz
	typedef enum logic [2:0] {
		RM_RNE = 3'd0,
		RM_RTZ = 3'd1,
		RM_RDN = 3'd2,
		RM_RUP = 3'd3,
		RM_RMM = 3'd4
	} fpu_rm_t;

	// accrued exception bits, msb first as in status
	typedef struct packed {
		logic nv;
		logic of;
		logic nx;
	} fpu_flags_t;

	typedef struct packed {
		logic [WORD_W-1:0] operand;
		fpu_cvt_type_t op;
		fpu_rm_t rm;
	} fcvt_cmd_t;

	typedef struct packed {
		logic [WORD_W-1:0] value;
		fpu_flags_t flags;
	} fcvt_res_t;

endpackage
